//--- src/port_regs_pkg.sv
// Register map of one port; only word-aligned byte offsets decode, all others are unmapped
package port_regs_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////////////

  parameter int data_width = 32;
  parameter int addr_width = 8;

  ////////////////////////////////////////////////////////////////////////////
  // Constants and register defaults
  ////////////////////////////////////////////////////////////////////////////

  // Low half of the ID word
  parameter logic [15:0] block_id = 16'hb10c;
  parameter logic [31:0] version_default = 32'h0001_0200;
  // Added to whatever the CPU last wrote into debug
  parameter logic [31:0] debug_default = 32'h0000_1000;

  // Depth of the response buffer, also the number of decode credits
  parameter int rsp_credits = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Address map
  ////////////////////////////////////////////////////////////////////////////

  parameter logic [addr_width-1:0] addr_id           = 8'h00;
  parameter logic [addr_width-1:0] addr_version      = 8'h04;
  parameter logic [addr_width-1:0] addr_reset        = 8'h08;
  parameter logic [addr_width-1:0] addr_flip         = 8'h0c;
  parameter logic [addr_width-1:0] addr_debug        = 8'h10;
  parameter logic [addr_width-1:0] addr_interface_id = 8'h14;
  parameter logic [addr_width-1:0] addr_pkt_in       = 8'h18;
  parameter logic [addr_width-1:0] addr_pkt_out      = 8'h1c;
  parameter logic [addr_width-1:0] addr_mac_status   = 8'h20;
  parameter logic [addr_width-1:0] addr_pcs_status   = 8'h24;

  // Soft reset bits, both self-clearing
  parameter int rst_clear_counters_bit = 0;
  parameter int rst_registers_bit      = 4;

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } reg_op_e;

  typedef enum logic [3:0] {
    sel_id           = 4'h0,
    sel_version      = 4'h1,
    sel_reset        = 4'h2,
    sel_flip         = 4'h3,
    sel_debug        = 4'h4,
    sel_interface_id = 4'h5,
    sel_pkt_in       = 4'h6,
    sel_pkt_out      = 4'h7,
    sel_mac_status   = 4'h8,
    sel_pcs_status   = 4'h9,
    sel_none         = 4'hf
  } reg_sel_e;

endpackage

//--- src/reg_cmd_if.sv
// Decoded command bus; one-cycle valid pulse and no ready, since credits guarantee room
`timescale 1ns/10ps

interface reg_cmd_if;

  logic                                  valid;
  port_regs_pkg::reg_op_e                op;
  port_regs_pkg::reg_sel_e               sel;
  logic [port_regs_pkg::data_width-1:0]  wdata;

  // Decode side
  modport sender (
    output valid,
    output op,
    output sel,
    output wdata
  );

  // Execute side
  modport receiver (
    input valid,
    input op,
    input sel,
    input wdata
  );

endinterface

//--- src/reg_rsp_if.sv
// Read result bus; one-cycle valid pulse per command, the receiver must always accept it
`timescale 1ns/10ps

interface reg_rsp_if;

  logic                                  valid;
  logic [port_regs_pkg::data_width-1:0]  rdata;
  logic                                  err;

  modport sender (
    output valid,
    output rdata,
    output err
  );

  modport receiver (
    input valid,
    input rdata,
    input err
  );

endinterface

//--- src/reg_decode.sv
// Request stage; accepts only while credits remain and registers each request for one cycle
`timescale 1ns/10ps

module reg_decode (
  input  logic                                  core_clk,
  input  logic                                  rst_n,
  input  logic                                  cpu_req_valid,
  input  logic                                  cpu_req_op,
  input  logic [port_regs_pkg::addr_width-1:0]  cpu_req_addr,
  input  logic [port_regs_pkg::data_width-1:0]  cpu_req_wdata,
  output logic                                  cpu_req_ready,
  input  logic                                  credit_return,
  reg_cmd_if.sender                             cmd
);

  localparam int cw = $clog2(port_regs_pkg::rsp_credits + 1);

  logic [cw-1:0]            credits;
  logic                     accept;
  port_regs_pkg::reg_sel_e  sel_d;

  // Free slots in the response buffer
  assign cpu_req_ready = (credits != '0);
  assign accept        = cpu_req_valid & cpu_req_ready;

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      credits <= cw'(port_regs_pkg::rsp_credits);
    end else begin
      case ({accept, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cpu_req_addr)
      port_regs_pkg::addr_id:           sel_d = port_regs_pkg::sel_id;
      port_regs_pkg::addr_version:      sel_d = port_regs_pkg::sel_version;
      port_regs_pkg::addr_reset:        sel_d = port_regs_pkg::sel_reset;
      port_regs_pkg::addr_flip:         sel_d = port_regs_pkg::sel_flip;
      port_regs_pkg::addr_debug:        sel_d = port_regs_pkg::sel_debug;
      port_regs_pkg::addr_interface_id: sel_d = port_regs_pkg::sel_interface_id;
      port_regs_pkg::addr_pkt_in:       sel_d = port_regs_pkg::sel_pkt_in;
      port_regs_pkg::addr_pkt_out:      sel_d = port_regs_pkg::sel_pkt_out;
      port_regs_pkg::addr_mac_status:   sel_d = port_regs_pkg::sel_mac_status;
      port_regs_pkg::addr_pcs_status:   sel_d = port_regs_pkg::sel_pcs_status;
      default:                          sel_d = port_regs_pkg::sel_none;
    endcase
  end

  // Command pulse for the execute stage
  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      cmd.valid <= 1'b0;
    end else begin
      cmd.valid <= accept;
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      cmd.op    <= port_regs_pkg::reg_op_e'(cpu_req_op);
      cmd.sel   <= sel_d;
      cmd.wdata <= cpu_req_wdata;
    end
  end

  // Credits stay within the buffer depth
  a_credit_range: assert property (@(posedge core_clk) disable iff (!rst_n)
    credits <= cw'(port_regs_pkg::rsp_credits));

  // A credit only comes back while a response is outstanding
  a_credit_return: assert property (@(posedge core_clk) disable iff (!rst_n)
    credit_return |-> credits != cw'(port_regs_pkg::rsp_credits));

endmodule

//--- src/reg_execute.sv
// Register file and packet counters; cnt_width from 4 to 32, counter reads are destructive
`timescale 1ns/10ps

module reg_execute #(
  parameter int cnt_width = 32
) (
  input  logic        core_clk,
  input  logic        rst_n,
  input  logic [7:0]  interface_number,
  input  logic [1:0]  mac_status,
  input  logic [7:0]  pcs_status,
  input  logic        rx_valid,
  input  logic        rx_ready,
  input  logic        rx_last,
  input  logic        tx_valid,
  input  logic        tx_ready,
  input  logic        tx_last,
  reg_cmd_if.receiver cmd,
  reg_rsp_if.sender   rsp
);

  localparam int dw = port_regs_pkg::data_width;
  localparam int fw = cnt_width - 1;

  logic [dw-1:0]        flip_q;
  logic [dw-1:0]        debug_q;
  logic [cnt_width-1:0] pkt_in;
  logic [cnt_width-1:0] pkt_out;
  logic [1:0]           mac_q;
  logic [7:0]           pcs_q;
  logic [dw-1:0]        rd_data;

  logic wr_en;
  logic rd_en;
  logic rx_hit;
  logic tx_hit;
  logic clear_counters;
  logic reset_registers;
  logic clr_pkt_in;
  logic clr_pkt_out;

  // Top bit is a sticky overflow, the field below it counts and wraps
  function automatic logic [cnt_width-1:0] cnt_next(
    input logic [cnt_width-1:0] cnt,
    input logic                 hit,
    input logic                 clr
  );
    logic [fw-1:0] field;
    logic          ovf;
    field = cnt[fw-1:0] + fw'(hit);
    ovf   = cnt[cnt_width-1] | (hit & (&cnt[fw-1:0]));
    if (clr) begin
      return '0;
    end
    return {ovf, field};
  endfunction

  assign wr_en  = cmd.valid && (cmd.op == port_regs_pkg::op_write);
  assign rd_en  = cmd.valid && (cmd.op == port_regs_pkg::op_read);
  assign rx_hit = rx_valid & rx_ready & rx_last;
  assign tx_hit = tx_valid & tx_ready & tx_last;

  ////////////////////////////////////////////////////////////////////////////
  // Soft reset and clears
  ////////////////////////////////////////////////////////////////////////////

  assign reset_registers = wr_en && (cmd.sel == port_regs_pkg::sel_reset) &&
                           cmd.wdata[port_regs_pkg::rst_registers_bit];
  assign clear_counters  = reset_registers ||
                           (wr_en && (cmd.sel == port_regs_pkg::sel_reset) &&
                            cmd.wdata[port_regs_pkg::rst_clear_counters_bit]);

  // Clear-on-read beats a packet on the same edge
  assign clr_pkt_in  = clear_counters || (rd_en && (cmd.sel == port_regs_pkg::sel_pkt_in));
  assign clr_pkt_out = clear_counters || (rd_en && (cmd.sel == port_regs_pkg::sel_pkt_out));

  always_ff @(posedge core_clk) begin
    if (!rst_n || reset_registers) begin
      flip_q  <= '0;
      debug_q <= '0;
    end else if (wr_en) begin
      if (cmd.sel == port_regs_pkg::sel_flip) begin
        flip_q <= cmd.wdata;
      end
      if (cmd.sel == port_regs_pkg::sel_debug) begin
        debug_q <= cmd.wdata;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      pkt_in  <= '0;
      pkt_out <= '0;
    end else begin
      pkt_in  <= cnt_next(pkt_in, rx_hit, clr_pkt_in);
      pkt_out <= cnt_next(pkt_out, tx_hit, clr_pkt_out);
    end
  end

  // Status snapshot, refreshed every cycle
  always_ff @(posedge core_clk) begin
    mac_q <= mac_status;
    pcs_q <= pcs_status;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and response
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (cmd.sel)
      port_regs_pkg::sel_id:           rd_data = {8'h00, interface_number,
                                                  port_regs_pkg::block_id};
      port_regs_pkg::sel_version:      rd_data = port_regs_pkg::version_default;
      port_regs_pkg::sel_flip:         rd_data = ~flip_q;
      port_regs_pkg::sel_debug:        rd_data = port_regs_pkg::debug_default + debug_q;
      port_regs_pkg::sel_interface_id: rd_data = dw'(interface_number);
      port_regs_pkg::sel_pkt_in:       rd_data = dw'(pkt_in);
      port_regs_pkg::sel_pkt_out:      rd_data = dw'(pkt_out);
      port_regs_pkg::sel_mac_status:   rd_data = dw'(mac_q);
      port_regs_pkg::sel_pcs_status:   rd_data = dw'(pcs_q);
      // Reset register and unmapped reads return zero
      default:                         rd_data = '0;
    endcase
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      rsp.valid <= 1'b0;
    end else begin
      rsp.valid <= cmd.valid;
    end
  end

  always_ff @(posedge core_clk) begin
    rsp.rdata <= (cmd.op == port_regs_pkg::op_write) ? '0 : rd_data;
    rsp.err   <= (cmd.sel == port_regs_pkg::sel_none);
  end

  // Overflow bit holds until a read or a soft reset clears the counter
  a_pkt_in_ovf_sticky: assert property (@(posedge core_clk) disable iff (!rst_n)
    (pkt_in[cnt_width-1] && !clr_pkt_in) |=> pkt_in[cnt_width-1]);

endmodule

//--- src/reg_result.sv
// Response FIFO toward the CPU; depth equals the credit count, so it never overflows
`timescale 1ns/10ps

module reg_result (
  input  logic                                  core_clk,
  input  logic                                  rst_n,
  reg_rsp_if.receiver                           rsp,
  output logic                                  cpu_rsp_valid,
  output logic [port_regs_pkg::data_width-1:0]  cpu_rsp_data,
  output logic                                  cpu_rsp_err,
  input  logic                                  cpu_rsp_ready,
  output logic                                  credit_return
);

  localparam int depth = port_regs_pkg::rsp_credits;
  localparam int pw    = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw    = $clog2(depth + 1);

  logic [port_regs_pkg::data_width-1:0] data_mem [depth];
  logic                                 err_mem  [depth];

  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic [cw-1:0] count;
  logic          push;
  logic          pop;
  logic          full;

  assign push = rsp.valid;
  assign pop  = cpu_rsp_valid & cpu_rsp_ready;
  assign full = (count == cw'(depth));

  // Oldest entry is always on the CPU port
  assign cpu_rsp_valid = (count != '0);
  assign cpu_rsp_data  = data_mem[rd_ptr];
  assign cpu_rsp_err   = err_mem[rd_ptr];

  // Each response that leaves frees one decode credit
  assign credit_return = pop;

  always_ff @(posedge core_clk) begin
    if (push) begin
      data_mem[wr_ptr] <= rsp.rdata;
      err_mem[wr_ptr]  <= rsp.err;
    end
  end

  always_ff @(posedge core_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == pw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == pw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Decode credits must keep results from arriving at a full buffer
  a_no_push_full: assert property (@(posedge core_clk) disable iff (!rst_n)
    !(push && full));

  // Held response stays put until the CPU takes it
  a_rsp_stable: assert property (@(posedge core_clk) disable iff (!rst_n)
    (cpu_rsp_valid && !cpu_rsp_ready) |=>
      (cpu_rsp_valid && $stable(cpu_rsp_data) && $stable(cpu_rsp_err)));

endmodule

//--- src/port_regs_top.sv
// Port register block top; single clock, interface_number must be static while in use
`timescale 1ns/10ps

module port_regs_top #(
  parameter int cnt_width = 32
) (
  input  logic                                  core_clk,
  input  logic                                  rst_n,
  input  logic [7:0]                            interface_number,
  input  logic [1:0]                            mac_status,
  input  logic [7:0]                            pcs_status,
  // Stream handshake taps
  input  logic                                  rx_valid,
  input  logic                                  rx_ready,
  input  logic                                  rx_last,
  input  logic                                  tx_valid,
  input  logic                                  tx_ready,
  input  logic                                  tx_last,
  // CPU request
  input  logic                                  cpu_req_valid,
  input  logic                                  cpu_req_op,
  input  logic [port_regs_pkg::addr_width-1:0]  cpu_req_addr,
  input  logic [port_regs_pkg::data_width-1:0]  cpu_req_wdata,
  output logic                                  cpu_req_ready,
  // CPU response
  output logic                                  cpu_rsp_valid,
  output logic [port_regs_pkg::data_width-1:0]  cpu_rsp_data,
  output logic                                  cpu_rsp_err,
  input  logic                                  cpu_rsp_ready
);

  logic credit_return;

  reg_cmd_if cmd_bus ();
  reg_rsp_if rsp_bus ();

  reg_decode u_decode (
    .core_clk      (core_clk),
    .rst_n         (rst_n),
    .cpu_req_valid (cpu_req_valid),
    .cpu_req_op    (cpu_req_op),
    .cpu_req_addr  (cpu_req_addr),
    .cpu_req_wdata (cpu_req_wdata),
    .cpu_req_ready (cpu_req_ready),
    .credit_return (credit_return),
    .cmd           (cmd_bus.sender)
  );

  reg_execute #(
    .cnt_width (cnt_width)
  ) u_execute (
    .core_clk         (core_clk),
    .rst_n            (rst_n),
    .interface_number (interface_number),
    .mac_status       (mac_status),
    .pcs_status       (pcs_status),
    .rx_valid         (rx_valid),
    .rx_ready         (rx_ready),
    .rx_last          (rx_last),
    .tx_valid         (tx_valid),
    .tx_ready         (tx_ready),
    .tx_last          (tx_last),
    .cmd              (cmd_bus.receiver),
    .rsp              (rsp_bus.sender)
  );

  // Returns one credit to decode per delivered response
  reg_result u_result (
    .core_clk      (core_clk),
    .rst_n         (rst_n),
    .rsp           (rsp_bus.receiver),
    .cpu_rsp_valid (cpu_rsp_valid),
    .cpu_rsp_data  (cpu_rsp_data),
    .cpu_rsp_err   (cpu_rsp_err),
    .cpu_rsp_ready (cpu_rsp_ready),
    .credit_return (credit_return)
  );

endmodule

//--- test/tb_port_regs_table.svh
// Expected values assume interface_number 0x5a, mac_status 2'b10, pcs_status 0xc3, cnt_width 8
  // Columns: rx packets, tx packets, op, byte address, write data,
  // expected data, expected err, back-pressure on the response port

  localparam port_regs_pkg::reg_op_e rd = port_regs_pkg::op_read;
  localparam port_regs_pkg::reg_op_e wr = port_regs_pkg::op_write;
  localparam logic [31:0] id_word = {8'h00, 8'h5a, port_regs_pkg::block_id};
  localparam logic [31:0] ver = port_regs_pkg::version_default;
  localparam logic [31:0] dbg = port_regs_pkg::debug_default;
  localparam int n_rows = 34;

  row_t rows [n_rows] = '{
    // Values right after reset
    '{0, 0, rd, 8'h00, 32'h0, id_word, 1'b0, 1'b0},
    '{0, 0, rd, 8'h04, 32'h0, ver, 1'b0, 1'b0},
    '{0, 0, rd, 8'h0c, 32'h0, 32'hffff_ffff, 1'b0, 1'b0},
    '{0, 0, rd, 8'h10, 32'h0, dbg, 1'b0, 1'b0},
    '{0, 0, rd, 8'h14, 32'h0, 32'h0000_005a, 1'b0, 1'b0},
    '{0, 0, rd, 8'h08, 32'h0, 32'h0, 1'b0, 1'b0},
    // Flip inverts, debug adds its default and wraps at 32 bits
    '{0, 0, wr, 8'h0c, 32'h1234_5678, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h0c, 32'h0, ~32'h1234_5678, 1'b0, 1'b0},
    '{0, 0, wr, 8'h10, 32'hffff_f123, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h10, 32'h0, dbg + 32'hffff_f123, 1'b0, 1'b0},
    // Counters, then clear-on-read
    '{3, 5, rd, 8'h18, 32'h0, 32'h3, 1'b0, 1'b0},
    '{0, 0, rd, 8'h1c, 32'h0, 32'h5, 1'b0, 1'b0},
    '{0, 0, rd, 8'h18, 32'h0, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h1c, 32'h0, 32'h0, 1'b0, 1'b0},
    // 7-bit field wraps after 128, sticky bit 7 stays
    '{130, 0, rd, 8'h18, 32'h0, 32'h82, 1'b0, 1'b0},
    // Soft reset bits
    '{4, 6, wr, 8'h08, 32'h1, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h18, 32'h0, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h1c, 32'h0, 32'h0, 1'b0, 1'b0},
    '{0, 0, wr, 8'h0c, 32'hdead_beef, 32'h0, 1'b0, 1'b0},
    '{0, 0, wr, 8'h10, 32'h0000_0042, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h10, 32'h0, dbg + 32'h42, 1'b0, 1'b0},
    '{0, 0, wr, 8'h08, 32'h10, 32'h0, 1'b0, 1'b0},
    '{0, 0, rd, 8'h0c, 32'h0, 32'hffff_ffff, 1'b0, 1'b0},
    '{0, 0, rd, 8'h10, 32'h0, dbg, 1'b0, 1'b0},
    // Unmapped address and a write to a read-only register
    '{0, 0, rd, 8'h40, 32'h0, 32'h0, 1'b1, 1'b0},
    '{0, 0, wr, 8'h04, 32'hffff_ffff, 32'h0, 1'b0, 1'b0},
    // Burst under random back-pressure
    '{0, 0, rd, 8'h04, 32'h0, ver, 1'b0, 1'b1},
    '{0, 0, rd, 8'h00, 32'h0, id_word, 1'b0, 1'b1},
    '{0, 0, rd, 8'h20, 32'h0, 32'h2, 1'b0, 1'b1},
    '{0, 0, rd, 8'h24, 32'h0, 32'hc3, 1'b0, 1'b1},
    '{7, 0, rd, 8'h18, 32'h0, 32'h7, 1'b0, 1'b1},
    '{0, 0, rd, 8'h3c, 32'h0, 32'h0, 1'b1, 1'b1},
    '{0, 0, rd, 8'h10, 32'h0, dbg, 1'b0, 1'b1},
    '{0, 0, rd, 8'h14, 32'h0, 32'h0000_005a, 1'b0, 1'b1}
  };

//--- test/tb_port_regs.sv
// Runs the DUT with cnt_width 8 and needs a simulator with timing support; stops at first error
`timescale 1ns/10ps

module tb_port_regs;

  typedef struct packed {
    int                      n_rx;
    int                      n_tx;
    port_regs_pkg::reg_op_e  op;
    logic [7:0]              addr;
    logic [31:0]             wdata;
    logic [31:0]             exp_data;
    logic                    exp_err;
    logic                    bp;
  } row_t;

  `include "tb_port_regs_table.svh"

  logic        core_clk;
  logic        rst_n;
  logic        rx_valid;
  logic        tx_valid;
  logic        cpu_req_valid;
  logic        cpu_req_op;
  logic [7:0]  cpu_req_addr;
  logic [31:0] cpu_req_wdata;
  logic        cpu_req_ready;
  logic        cpu_rsp_valid;
  logic [31:0] cpu_rsp_data;
  logic        cpu_rsp_err;
  logic        cpu_rsp_ready;
  integer      seed = 80;
  int          rsp_count = 0;

  // Single-beat packets, so last follows valid
  port_regs_top #(.cnt_width(8)) DUT (
    .core_clk(core_clk), .rst_n(rst_n), .interface_number(8'h5a),
    .mac_status(2'b10), .pcs_status(8'hc3),
    .rx_valid(rx_valid), .rx_ready(1'b1), .rx_last(rx_valid),
    .tx_valid(tx_valid), .tx_ready(1'b1), .tx_last(tx_valid),
    .cpu_req_valid(cpu_req_valid), .cpu_req_op(cpu_req_op), .cpu_req_addr(cpu_req_addr),
    .cpu_req_wdata(cpu_req_wdata), .cpu_req_ready(cpu_req_ready),
    .cpu_rsp_valid(cpu_rsp_valid), .cpu_rsp_data(cpu_rsp_data), .cpu_rsp_err(cpu_rsp_err),
    .cpu_rsp_ready(cpu_rsp_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic longint watchdog_cycles();
    longint pkts;
    pkts = 0;
    foreach (rows[i]) pkts += rows[i].n_rx + rows[i].n_tx;
    return n_rows * (pkts + 20);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      $display("TB FAILED");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  // Starts one cycle later so a counter read just issued cannot swallow a packet
  task automatic inject_packets(input int n_rx, input int n_tx);
    for (int i = 0; i < ((n_rx > n_tx) ? n_rx : n_tx); i++) begin
      @(negedge core_clk);
      rx_valid = (i < n_rx);
      tx_valid = (i < n_tx);
    end
    @(negedge core_clk);
    rx_valid = 1'b0;
    tx_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Clock, watchdog, response checker and driver
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    core_clk = 1'b0;
    forever #50 core_clk = ~core_clk;
  end

  initial begin
    longint limit;
    limit = watchdog_cycles() * 100;
    #(limit);
    $display("TB FAILED");
    $fatal(1, "Timeout, the responses did not all arrive in time");
  end

  // Ready is set on the falling edge, so a transfer at the next rising edge is known here
  initial begin
    integer rnd;
    @(posedge rst_n);
    forever begin
      @(negedge core_clk);
      if (rsp_count < n_rows && rows[rsp_count].bp) begin
        rnd = $random(seed);
        cpu_rsp_ready = rnd[0];
      end else begin
        cpu_rsp_ready = 1'b1;
      end
      if (cpu_rsp_valid && cpu_rsp_ready) begin
        if (rsp_count >= n_rows) begin
          $display("TB FAILED");
          $fatal(1, "A response arrived with no request outstanding");
        end else begin
          check_value("cpu_rsp_data", cpu_rsp_data, rows[rsp_count].exp_data);
          check_value("cpu_rsp_err", 32'(cpu_rsp_err), 32'(rows[rsp_count].exp_err));
          rsp_count++;
        end
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    rx_valid = 1'b0;
    tx_valid = 1'b0;
    cpu_req_valid = 1'b0;
    cpu_req_op = 1'b0;
    cpu_req_addr = '0;
    cpu_req_wdata = '0;
    cpu_rsp_ready = 1'b1;
    repeat (4) @(posedge core_clk);
    @(negedge core_clk);
    rst_n = 1'b1;
    // Idle handshake after reset, with every credit available
    check_value("cpu_req_ready", 32'(cpu_req_ready), 32'h1);
    check_value("cpu_rsp_valid", 32'(cpu_rsp_valid), 32'h0);
    foreach (rows[i]) begin
      if (rows[i].n_rx + rows[i].n_tx > 0) inject_packets(rows[i].n_rx, rows[i].n_tx);
      cpu_req_valid = 1'b1;
      cpu_req_op = rows[i].op;
      cpu_req_addr = rows[i].addr;
      cpu_req_wdata = rows[i].wdata;
      while (!cpu_req_ready) @(negedge core_clk);
      @(negedge core_clk);
      cpu_req_valid = 1'b0;
    end
    wait (rsp_count == n_rows);
    repeat (4) @(negedge core_clk);
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- files.f
+incdir+test
src/port_regs_pkg.sv
src/reg_cmd_if.sv
src/reg_rsp_if.sv
src/reg_decode.sv
src/reg_execute.sv
src/reg_result.sv
src/port_regs_top.sv
test/tb_port_regs.sv

//--- run.sh
#!/bin/sh
# Builds the register block testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_port_regs -o tb_port_regs
./obj_dir/tb_port_regs
